// ==== build.f ====
+incdir+verif
hw/spiLoopPkg.sv
hw/spiShifter.sv
hw/spiCmdCtrl.sv
hw/loopMem.sv
hw/regBank.sv
hw/spiLoop.sv
verif/spiLoopTb.sv

// ==== hw/loopMem.sv ====
module loopMem
  import spiLoopPkg::*;
#(
  parameter int AddrWidth = 12
) (
  input  logic                 SysClk,
  input  logic                 memWe,
  input  logic [AddrWidth-1:0] memWrAddr,
  input  logic [ByteW-1:0]     memWrData,
  input  logic [AddrWidth-1:0] memRdAddr,
  output logic [ByteW-1:0]     memRdData
);

  localparam int Depth = 2 ** AddrWidth;

  logic [ByteW-1:0] mem [Depth];

  // simple dual port, read returns old data on collision
  always_ff @(posedge SysClk) begin
    if (memWe) begin
      mem[memWrAddr] <= memWrData;
    end
    memRdData <= mem[memRdAddr];   // registered read
  end

endmodule

// ==== hw/regBank.sv ====
module regBank
  import spiLoopPkg::*;
#(
  parameter int RegCount = 16
) (
  input  logic                        SysClk,
  input  logic                        rstN,
  input  logic                        regWe,
  input  logic [$clog2(RegCount)-1:0] regIdx,
  input  logic [RegW-1:0]             regWrData,
  output logic [RegW-1:0]             regRdData
);

  logic [RegW-1:0] regs [RegCount];

  always_ff @(posedge SysClk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe) begin
      regs[regIdx] <= regWrData;
    end
  end

  assign regRdData = regs[regIdx];   // combinational read

endmodule

// ==== hw/spiCmdCtrl.sv ====
module spiCmdCtrl
  import spiLoopPkg::*;
#(
  parameter int AddrWidth = 12,
  parameter int RegCount  = 16
) (
  input  logic                        SysClk,
  input  logic                        rstN,
  input  logic [ByteW-1:0]            rxByte,
  input  logic                        rxValid,
  input  logic                        frameStart,
  input  logic                        frameActive,
  output logic [ByteW-1:0]            txByte,
  output logic                        memWe,
  output logic [AddrWidth-1:0]        memWrAddr,
  output logic [ByteW-1:0]            memWrData,
  output logic [AddrWidth-1:0]        memRdAddr,
  input  logic [ByteW-1:0]            memRdData,
  output logic                        regWe,
  output logic [$clog2(RegCount)-1:0] regIdx,
  output logic [RegW-1:0]             regWrData,
  input  logic [RegW-1:0]             regRdData
);

  localparam int IdxW = $clog2(RegCount);

  ctrlStateE            state;
  spiOpE                opCode;
  logic [ByteW-1:0]     addrHi;
  logic [2*ByteW-1:0]   fullAddr;
  logic [AddrWidth-1:0] addr;       // next byte to transfer
  logic [AddrWidth-1:0] shownAddr;  // last byte sent on a read
  logic                 rdReq;
  logic                 rdLoad;
  logic                 regLatch;
  logic [1:0]           wrCnt;
  logic [RegW-1:0]      wrShift;
  logic [RegW-1:0]      rdShift;

  assign fullAddr = {addrHi, rxByte};

  // prefetch for one cycle, then point back at the byte just sent
  assign memRdAddr = rdReq ? addr : shownAddr;
  assign regWrData = wrShift;

  ////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////
  always_ff @(posedge SysClk or negedge rstN) begin
    if (!rstN) begin
      state     <= IDLE;
      opCode    <= OP_MEM_WRITE;
      addr      <= '0;
      shownAddr <= '0;
      rdReq     <= 1'b0;
      rdLoad    <= 1'b0;
      regLatch  <= 1'b0;
      wrCnt     <= '0;
      memWe     <= 1'b0;
      regWe     <= 1'b0;
      regIdx    <= '0;
      txByte    <= '0;
    end else if (!frameActive || frameStart) begin
      // ss high aborts, new frame starts clean
      state    <= IDLE;
      rdReq    <= 1'b0;
      rdLoad   <= 1'b0;
      regLatch <= 1'b0;
      wrCnt    <= '0;
      memWe    <= 1'b0;
      regWe    <= 1'b0;
      txByte   <= '0;
    end else begin
      memWe    <= 1'b0;
      regWe    <= 1'b0;
      rdReq    <= 1'b0;
      regLatch <= 1'b0;
      rdLoad   <= rdReq;       // ram data is back one cycle later
      if (rdLoad) begin
        txByte <= memRdData;
      end
      if (regLatch) begin
        txByte <= regRdData[RegW-1 -: ByteW];
      end
      if (rxValid) begin
        unique case (state)
          IDLE: begin
            opCode <= spiOpE'(rxByte);
            case (spiOpE'(rxByte))
              OP_MEM_WRITE, OP_MEM_READ: state <= ADDR_HI;
              OP_REG_WRITE, OP_REG_READ: state <= REG_IDX;
              default:                   state <= DISCARD;
            endcase
          end
          ADDR_HI: state <= ADDR_LO;
          ADDR_LO: begin
            addr <= fullAddr[AddrWidth-1:0];
            if (opCode == OP_MEM_READ) begin
              state <= MEM_RD;
              rdReq <= 1'b1;   // fetch start address
            end else begin
              state <= MEM_WR;
            end
          end
          MEM_WR: begin
            memWe <= 1'b1;
            addr  <= addr + AddrWidth'(1);   // wraps at the top
          end
          MEM_RD: begin
            shownAddr <= addr;
            addr      <= addr + AddrWidth'(1);
            rdReq     <= 1'b1;
          end
          REG_IDX: begin
            regIdx <= rxByte[IdxW-1:0];
            wrCnt  <= '0;
            if (opCode == OP_REG_READ) begin
              state    <= REG_RD;
              regLatch <= 1'b1;
            end else begin
              state <= REG_WR;
            end
          end
          REG_WR: begin
            wrCnt <= wrCnt + 2'd1;
            if (wrCnt == 2'd3) begin
              regWe <= 1'b1;   // all four bytes in
              state <= DISCARD;
            end
          end
          REG_RD: txByte <= rdShift[RegW-ByteW-1 -: ByteW];
          DISCARD: ;           // zeros until ss rises
          default: state <= DISCARD;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////
  always_ff @(posedge SysClk) begin
    if (rxValid && state == ADDR_HI) begin
      addrHi <= rxByte;
    end
    if (rxValid && state == MEM_WR) begin
      memWrAddr <= addr;
      memWrData <= rxByte;
    end
    if (rxValid && state == REG_WR) begin
      wrShift <= {wrShift[RegW-ByteW-1:0], rxByte};   // msb first
    end
    if (regLatch) begin
      rdShift <= regRdData;
    end else if (rxValid && state == REG_RD) begin
      rdShift <= {rdShift[RegW-ByteW-1:0], {ByteW{1'b0}}};
    end
  end

endmodule

// ==== hw/spiLoop.sv ====
module spiLoop
  import spiLoopPkg::*;
#(
  parameter int AddrWidth = 12,
  parameter int RegCount  = 16
) (
  input  logic             SysClk,
  input  logic             rstN,
  input  logic             spiSs,
  input  logic             spiMosi,
  input  logic             spiClk,
  output logic             spiMiso,
  output logic [ByteW-1:0] leds
);

  logic [ByteW-1:0]            rxByte;
  logic                        rxValid;
  logic                        frameStart;
  logic                        frameActive;
  logic [ByteW-1:0]            txByte;

  // memory ports
  logic                        memWe;
  logic [AddrWidth-1:0]        memWrAddr;
  logic [ByteW-1:0]            memWrData;
  logic [AddrWidth-1:0]        memRdAddr;
  logic [ByteW-1:0]            memRdData;

  // register ports
  logic                        regWe;
  logic [$clog2(RegCount)-1:0] regIdx;
  logic [RegW-1:0]             regWrData;
  logic [RegW-1:0]             regRdData;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////
  spiShifter uShifter (
    .SysClk     (SysClk),
    .rstN       (rstN),
    .spiSs      (spiSs),
    .spiMosi    (spiMosi),
    .spiClk     (spiClk),
    .spiMiso    (spiMiso),
    .rxByte     (rxByte),
    .rxValid    (rxValid),
    .frameStart (frameStart),
    .frameActive(frameActive),
    .txByte     (txByte)
  );

  spiCmdCtrl #(.AddrWidth(AddrWidth), .RegCount(RegCount)) uCtrl (
    .SysClk     (SysClk),
    .rstN       (rstN),
    .rxByte     (rxByte),
    .rxValid    (rxValid),
    .frameStart (frameStart),
    .frameActive(frameActive),
    .txByte     (txByte),
    .memWe      (memWe),
    .memWrAddr  (memWrAddr),
    .memWrData  (memWrData),
    .memRdAddr  (memRdAddr),
    .memRdData  (memRdData),
    .regWe      (regWe),
    .regIdx     (regIdx),
    .regWrData  (regWrData),
    .regRdData  (regRdData)
  );

  loopMem #(.AddrWidth(AddrWidth)) uMem (
    .SysClk   (SysClk),
    .memWe    (memWe),
    .memWrAddr(memWrAddr),
    .memWrData(memWrData),
    .memRdAddr(memRdAddr),
    .memRdData(memRdData)
  );

  regBank #(.RegCount(RegCount)) uRegs (
    .SysClk   (SysClk),
    .rstN     (rstN),
    .regWe    (regWe),
    .regIdx   (regIdx),
    .regWrData(regWrData),
    .regRdData(regRdData)
  );

  assign leds = memRdData;   // straight off the ram read register

endmodule

// ==== hw/spiLoopPkg.sv ====
package spiLoopPkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int ByteW = 8;   // one SPI byte, one memory word
  localparam int RegW  = 32;  // one register

  // first byte of every frame
  typedef enum logic [ByteW-1:0] {
    OP_MEM_WRITE = 8'h01,
    OP_MEM_READ  = 8'h02,
    OP_REG_WRITE = 8'h03,
    OP_REG_READ  = 8'h04
  } spiOpE;

  // frame controller states
  typedef enum logic [3:0] {
    IDLE,
    ADDR_HI,
    ADDR_LO,
    MEM_WR,
    MEM_RD,
    REG_IDX,
    REG_WR,
    REG_RD,
    DISCARD      // unknown opcode, wait for ss high
  } ctrlStateE;

endpackage

// ==== hw/spiShifter.sv ====
module spiShifter
  import spiLoopPkg::*;
(
  input  logic             SysClk,
  input  logic             rstN,
  input  logic             spiSs,
  input  logic             spiMosi,
  input  logic             spiClk,
  output logic             spiMiso,
  output logic [ByteW-1:0] rxByte,
  output logic             rxValid,
  output logic             frameStart,
  output logic             frameActive,
  input  logic [ByteW-1:0] txByte
);

  localparam int CntW = $clog2(ByteW);

  logic [1:0]       ssSync;
  logic [1:0]       sclkSync;
  logic [1:0]       mosiSync;
  logic             ssPrev;
  logic             sclkPrev;
  logic             sclkRise;
  logic             sclkFall;
  logic             ssFall;
  logic [CntW-1:0]  bitCnt;
  logic [ByteW-1:0] shiftIn;
  logic [ByteW-1:0] shiftOut;

  ////////////////////////////////////////
  // pin synchronizers
  ////////////////////////////////////////
  always_ff @(posedge SysClk or negedge rstN) begin
    if (!rstN) begin
      ssSync   <= 2'b11;   // idle deselected
      sclkSync <= 2'b00;
      mosiSync <= 2'b00;
      ssPrev   <= 1'b1;
      sclkPrev <= 1'b0;
    end else begin
      ssSync   <= {ssSync[0], spiSs};
      sclkSync <= {sclkSync[0], spiClk};
      mosiSync <= {mosiSync[0], spiMosi};
      ssPrev   <= ssSync[1];
      sclkPrev <= sclkSync[1];
    end
  end

  assign sclkRise    = sclkSync[1] & ~sclkPrev;
  assign sclkFall    = ~sclkSync[1] & sclkPrev;
  assign ssFall      = ~ssSync[1] & ssPrev;
  assign frameActive = ~ssSync[1];

  ////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////
  always_ff @(posedge SysClk or negedge rstN) begin
    if (!rstN) begin
      bitCnt     <= '0;
      shiftIn    <= '0;
      shiftOut   <= '0;
      rxValid    <= 1'b0;
      frameStart <= 1'b0;
    end else begin
      frameStart <= ssFall;
      if (ssSync[1]) begin
        // deselected, partial byte is dropped
        bitCnt   <= '0;
        shiftIn  <= '0;
        shiftOut <= '0;
        rxValid  <= 1'b0;
      end else begin
        rxValid <= 1'b0;
        // mode 0 sample on rising edge
        if (sclkRise) begin
          shiftIn <= {shiftIn[ByteW-2:0], mosiSync[1]};
          bitCnt  <= bitCnt + 1'b1;
          rxValid <= (bitCnt == CntW'(ByteW - 1));
        end
        if (ssFall) begin
          shiftOut <= txByte;                        // first byte of the frame
        end else if (sclkFall) begin
          if (bitCnt == '0) begin
            shiftOut <= txByte;                      // byte boundary
          end else begin
            shiftOut <= {shiftOut[ByteW-2:0], 1'b0};
          end
        end
      end
    end
  end

  assign rxByte  = shiftIn;
  assign spiMiso = shiftOut[ByteW-1];  // msb first

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the spiLoop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module spiLoopTb -o spiLoopSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/spiLoopSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

# pass only on the exact pass line
if echo "$simOut" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== verif/spiMasterTasks.svh ====
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// SPI mode 0 master, pins change on the falling SysClk edge
localparam int HalfPer = 8;   // SysClk cycles per SPI half period

logic [ByteW-1:0] txQ[$];   // bytes of the next frame
logic [ByteW-1:0] rxQ[$];   // MISO bytes of the last frame

task automatic halfPeriod();
  for (int i = 0; i < HalfPer; i++) begin
    @(negedge SysClk);
  end
endtask

// msb first, nBits below ByteW leaves the byte unfinished
task automatic shiftBits(input logic [ByteW-1:0] txb, input int nBits,
                         output logic [ByteW-1:0] rxb);
  bit seen;
  rxb = '0;
  for (int b = ByteW - 1; b >= ByteW - nBits; b--) begin
    spiMosi = txb[b];
    halfPeriod();
    spiClk = 1'b1;
    rxb[b] = spiMiso;   // sampled with the rising edge
    seen = 1'b0;
    // high phase doubles as the rxValid timeout
    for (int i = 0; i < HalfPer; i++) begin
      @(negedge SysClk);
      seen |= UUT.rxValid;
    end
    if (b == 0 && !seen) begin
      timeoutFail("DUT gave no rxValid within half an SPI period of the eighth bit");
    end
    spiClk = 1'b0;
  end
endtask

// whole frame from txQ, then an optional cut-off byte
task automatic runFrame(input int partialBits);
  logic [ByteW-1:0] rxb;
  rxQ.delete();
  @(negedge SysClk);
  spiSs = 1'b0;
  foreach (txQ[k]) begin
    shiftBits(txQ[k], ByteW, rxb);
    rxQ.push_back(rxb);
  end
  if (partialBits > 0) begin
    shiftBits(8'hA5, partialBits, rxb);
  end
  halfPeriod();
  spiSs = 1'b1;
  halfPeriod();
  halfPeriod();   // deselect settles through the synchronizer
endtask

// opcode, address high and low, then wrData
task automatic memFrame(input logic [ByteW-1:0] op, input logic [AddrW-1:0] addr,
                        input int partialBits);
  txQ.delete();
  txQ.push_back(op);
  txQ.push_back(ByteW'(addr >> ByteW));
  txQ.push_back(addr[ByteW-1:0]);
  foreach (wrData[k]) begin
    txQ.push_back(wrData[k]);
  end
  runFrame(partialBits);
endtask

task automatic regFrame(input bit isRead, input logic [IdxW-1:0] idx,
                        input logic [RegW-1:0] value);
  txQ.delete();
  txQ.push_back(isRead ? OP_REG_READ : OP_REG_WRITE);
  txQ.push_back(ByteW'(idx));
  for (int k = RegW / ByteW - 1; k >= 0; k--) begin
    txQ.push_back(value[k*ByteW +: ByteW]);   // msb first
  end
  runFrame(0);
endtask

`endif

// ==== verif/spiLoopTb.sv ====
module spiLoopTb
  import spiLoopPkg::*;
();

  localparam int AddrW    = 12;
  localparam int NumRegs  = 16;
  localparam int IdxW     = $clog2(NumRegs);
  localparam int MemDepth = 2 ** AddrW;
  localparam int ClkPer   = 100;

  logic             SysClk;
  logic             rstN;
  logic             spiSs;
  logic             spiMosi;
  logic             spiClk;
  logic             spiMiso;
  logic [ByteW-1:0] leds;

  // scoreboard model
  logic [ByteW-1:0] memModel [MemDepth];
  logic [RegW-1:0]  regModel [NumRegs];
  logic [ByteW-1:0] wrData[$];
  logic [AddrW-1:0] knownBase;   // region with known contents
  int               knownLen;
  int               checkCount;
  int               errCount;
  int               testCount;
  int               errBase;

  spiLoop #(.AddrWidth(AddrW), .RegCount(NumRegs)) UUT (
    .SysClk (SysClk),
    .rstN   (rstN),
    .spiSs  (spiSs),
    .spiMosi(spiMosi),
    .spiClk (spiClk),
    .spiMiso(spiMiso),
    .leds   (leds)
  );

  always #(ClkPer / 2) SysClk = ~SysClk;

  task automatic timeoutFail(input string what);
    $display("timeout: %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic compareValue(input string what, input logic [RegW-1:0] got,
                              input logic [RegW-1:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
      errCount++;
    end
  endtask

  `include "spiMasterTasks.svh"

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic testDone(input string name);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, name, errCount - errBase);
    errBase = errCount;
  endtask

  // random bytes into the model, then out on MOSI
  task automatic writeRandom(input logic [AddrW-1:0] base, input int n, input int partialBits);
    wrData.delete();
    for (int k = 0; k < n; k++) begin
      wrData.push_back(ByteW'($urandom));
      memModel[AddrW'(base + k)] = wrData[k];   // wraps at the top
    end
    memFrame(OP_MEM_WRITE, base, partialBits);
  endtask

  task automatic checkMem(input logic [AddrW-1:0] base, input int n);
    wrData.delete();
    for (int k = 0; k < n; k++) begin
      wrData.push_back('0);
    end
    memFrame(OP_MEM_READ, base, 0);
    for (int k = 0; k < 3; k++) begin
      compareValue("spiMiso header", RegW'(rxQ[k]), '0);   // opcode and address
    end
    for (int k = 0; k < n; k++) begin
      compareValue("spiMiso data", RegW'(rxQ[k + 3]), RegW'(memModel[AddrW'(base + k)]));
    end
    compareValue("leds", RegW'(leds), RegW'(memModel[AddrW'(base + n - 1)]));
  endtask

  task automatic checkReg(input logic [IdxW-1:0] idx);
    regFrame(1'b1, idx, '0);
    compareValue("spiMiso register", {rxQ[2], rxQ[3], rxQ[4], rxQ[5]}, regModel[idx]);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    logic [AddrW-1:0] base;
    logic [IdxW-1:0]  idx;
    logic [ByteW-1:0] op;
    void'($urandom(32'h5052));
    SysClk     = 1'b0;
    rstN       = 1'b0;
    spiSs      = 1'b1;
    spiMosi    = 1'b0;
    spiClk     = 1'b0;
    checkCount = 0;
    errCount   = 0;
    testCount  = 0;
    errBase    = 0;
    repeat (3) @(negedge SysClk);
    rstN = 1'b1;
    halfPeriod();

    compareValue("spiMiso", RegW'(spiMiso), '0);
    for (int r = 0; r < NumRegs; r++) begin
      regModel[r] = '0;
      checkReg(IdxW'(r));
    end
    testDone("registers after reset");

    knownBase = AddrW'($urandom);
    knownLen  = 6 + int'($urandom % 6);
    writeRandom(knownBase, knownLen, 0);
    checkMem(knownBase, knownLen);
    testDone("memory loopback");

    writeRandom(AddrW'(MemDepth - 2), 4, 0);   // 4094, 4095, 0, 1
    checkMem(AddrW'(MemDepth - 2), 4);
    testDone("address wrap");

    idx = IdxW'($urandom);
    regModel[IdxW'(idx + 1)] = $urandom;   // neighbour first
    regFrame(1'b0, IdxW'(idx + 1), regModel[IdxW'(idx + 1)]);
    regModel[idx] = $urandom;
    regFrame(1'b0, idx, regModel[idx]);
    checkReg(idx);
    checkReg(IdxW'(idx + 1));
    testDone("register write and read");

    // opcodes 5 and up are undefined
    op = ByteW'(5 + $urandom % 250);
    wrData.delete();
    for (int k = 0; k < 3; k++) begin
      wrData.push_back(ByteW'($urandom));
    end
    memFrame(op, knownBase, 0);
    foreach (rxQ[k]) begin
      compareValue("spiMiso discard", RegW'(rxQ[k]), '0);
    end
    checkMem(knownBase, knownLen);
    testDone("unknown opcode");

    base = AddrW'($urandom);
    writeRandom(base, 4, 0);
    writeRandom(base, 1, 3);   // one byte, then three bits of the next
    checkMem(base, 4);
    testDone("aborted frame");

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
